//--- logic/race_pkg.sv
`default_nettype none

package race_pkg;

    // fixed point
    localparam int FRAC_W    = 4;
    localparam int VEL_INT_W = 8;
    localparam int VEL_W     = VEL_INT_W + FRAC_W;
    localparam int MAP_X_W   = 11;
    localparam int MAP_Y_W   = 10;
    localparam int POS_X_W   = MAP_X_W + FRAC_W;
    localparam int POS_Y_W   = MAP_Y_W + FRAC_W;
    localparam int ANG_W     = 9;
    localparam int ANG_WRAP  = 360;
    localparam int LAP_W     = 4;

    typedef logic signed [POS_X_W-1:0] pos_x_t;
    typedef logic signed [POS_Y_W-1:0] pos_y_t;
    typedef logic signed [VEL_W-1:0]   vel_t;
    typedef logic [ANG_W-1:0]          ang_t;   // degrees, 0 to 359
    typedef logic [LAP_W-1:0]          lap_t;

    // map bounds in whole units
    localparam int X_MIN = -750;
    localparam int X_MAX = 750;
    localparam int Y_MIN = -350;
    localparam int Y_MAX = 350;

    localparam int CAR1_INIT_X    = -100;
    localparam int CAR1_INIT_Y    = 200;
    localparam int CAR2_INIT_X    = -100;
    localparam int CAR2_INIT_Y    = 260;
    localparam int CAR_INIT_ANGLE = 0;

    // physics
    localparam int VEL_MAX        = 15;
    localparam int VEL_MAX_FX     = VEL_MAX << FRAC_W;
    localparam int FRICTION_SHIFT = 4;
    localparam int ACC_SHIFT      = 1;

    // cordic rotator
    localparam int ROT_ITERS   = 12;
    localparam int ROT_CNT_W   = 4;
    localparam int ROT_XW      = VEL_W + 2;           // room for the cordic gain
    localparam int ROT_ZW      = ANG_W + FRAC_W + 1;  // angle in 1/16 degree
    localparam int GAIN_FRAC_W = 9;

    // atan(2^-i) in degrees times 16
    localparam logic signed [ROT_ZW-1:0] CORDIC_ATAN [ROT_ITERS] =
        '{720, 425, 225, 114, 57, 29, 14, 7, 4, 2, 1, 0};
    localparam logic signed [GAIN_FRAC_W+1:0] CORDIC_GAIN_INV = 311;  // 0.6073 * 512

    localparam int FRAME_CYCLES = 32;
    localparam int FRAME_CNT_W  = $clog2(FRAME_CYCLES);

    localparam int LAP_LINE_X = 0;
    localparam int LAP_MAX    = 1;

    typedef enum logic [1:0] {S_IDLE, S_GAME, S_CAR1_WIN, S_CAR2_WIN} race_state_t;

    typedef enum logic [1:0] {
        GAME_RESULT_IDLE     = 2'd0,
        GAME_RESULT_CAR1_WIN = 2'd1,
        GAME_RESULT_CAR2_WIN = 2'd2
    } game_result_t;

endpackage

`default_nettype wire

//--- logic/rotate_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rotate_if;
    import race_pkg::*;

    logic start;     // one cycle, captures speed and heading
    vel_t speed;
    ang_t heading;
    vel_t vx;        // held between done pulses
    vel_t vy;
    logic done;

    modport requester (
        output start, speed, heading,
        input  vx, vy, done
    );

    modport rotator (
        input  start, speed, heading,
        output vx, vy, done
    );

endinterface

`default_nettype wire

//--- logic/vector_rotator.sv
`timescale 1ns/1ps
`default_nettype none

module vector_rotator (
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    rotate_if.rotator rot
);
    import race_pkg::*;

    logic signed [ANG_W:0]          ang_s;    // -179 to 180
    logic signed [ANG_W:0]          ang_f;    // folded into +-90
    logic                           flip;
    logic signed [ROT_XW-1:0]       x0;
    logic signed [ROT_ZW-1:0]       z0;
    logic signed [ROT_XW-1:0]       x_r, y_r, x_sh, y_sh, x_nxt, y_nxt;
    logic signed [ROT_ZW-1:0]       z_r, z_nxt;
    logic signed [ROT_XW+GAIN_FRAC_W+1:0] prod_x, prod_y;
    ang_t                           head_r;
    logic [ROT_CNT_W-1:0]           iter;
    logic                           busy;
    logic                           last;

    // fold the heading so the rotation stays inside the cordic range
    always_comb begin
        ang_s = $signed({1'b0, rot.heading});
        if (rot.heading > ang_t'(180))
            ang_s = ang_s - 10'sd360;
        flip  = 1'b0;
        ang_f = ang_s;
        if (ang_s > 10'sd90) begin
            ang_f = ang_s - 10'sd180;
            flip  = 1'b1;
        end else if (ang_s < -10'sd90) begin
            ang_f = ang_s + 10'sd180;
            flip  = 1'b1;
        end
        x0 = rot.speed;
        if (flip)
            x0 = -x0;               // half turn is a negated start vector
        z0 = ang_f;
        z0 = z0 <<< FRAC_W;
    end

    // one shift-add step
    always_comb begin
        x_sh = x_r >>> iter;
        y_sh = y_r >>> iter;
        if (z_r[ROT_ZW-1]) begin
            x_nxt = x_r + y_sh;
            y_nxt = y_r - x_sh;
            z_nxt = z_r + CORDIC_ATAN[iter];
        end else begin
            x_nxt = x_r - y_sh;
            y_nxt = y_r + x_sh;
            z_nxt = z_r - CORDIC_ATAN[iter];
        end
        prod_x = x_nxt * CORDIC_GAIN_INV;
        prod_y = y_nxt * CORDIC_GAIN_INV;
    end

    assign last = busy && (iter == ROT_CNT_W'(ROT_ITERS - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy     <= 1'b0;
            iter     <= '0;
            rot.done <= 1'b0;
        end else begin
            rot.done <= last;
            if (rot.start) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (last)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rot.start) begin
            x_r    <= x0;
            y_r    <= '0;
            z_r    <= z0;
            head_r <= rot.heading;
        end else if (busy) begin
            x_r <= x_nxt;
            y_r <= y_nxt;
            z_r <= z_nxt;
        end
        if (last) begin
            // exact zeros on the axes
            rot.vx <= (head_r == ang_t'(90) || head_r == ang_t'(270)) ?
                      '0 : vel_t'(prod_x >>> GAIN_FRAC_W);
            rot.vy <= (head_r == ang_t'(0) || head_r == ang_t'(180)) ?
                      '0 : vel_t'(prod_y >>> GAIN_FRAC_W);
        end
    end

endmodule

`default_nettype wire

//--- logic/lap_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module lap_tracker (
    input  wire logic             car1_v_decomposition_done,
    input  wire logic             i_rst_n,
    input  wire logic             i_update,
    input  wire logic             i_clear,
    input  wire race_pkg::pos_x_t i_x,   // position about to be taken
    input  wire race_pkg::pos_y_t i_y,
    output race_pkg::lap_t        o_lap
);
    import race_pkg::*;

    logic in0_r, in1_r;   // zones of the current position
    logic in0_nxt, in1_nxt;
    lap_t lap_r;

    // both zones sit above the x axis, split by the start line
    assign in0_nxt = (i_y > 0) && (i_x <  (LAP_LINE_X <<< FRAC_W));
    assign in1_nxt = (i_y > 0) && (i_x >= (LAP_LINE_X <<< FRAC_W));

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in0_r <= 1'b1;
            in1_r <= 1'b0;
            lap_r <= '0;
        end else if (i_clear) begin
            in0_r <= 1'b1;   // both cars start left of the line
            in1_r <= 1'b0;
            lap_r <= '0;
        end else if (i_update) begin
            in0_r <= in0_nxt;
            in1_r <= in1_nxt;
            if (in0_r && in1_nxt)
                lap_r <= lap_r + 1'b1;    // crossed forward
            else if (in1_r && in0_nxt && lap_r != '0)
                lap_r <= lap_r - 1'b1;    // backed over the line
        end
    end

    assign o_lap = lap_r;

endmodule

`default_nettype wire

//--- logic/car_dynamics.sv
`timescale 1ns/1ps
`default_nettype none

module car_dynamics (
    input  wire logic                            car1_v_decomposition_done,
    input  wire logic                            i_rst_n,
    input  wire logic                            i_frame_tick,
    input  wire logic                            i_racing,
    input  wire race_pkg::pos_x_t                i_init_x,
    input  wire race_pkg::pos_y_t                i_init_y,
    input  wire logic [2:0]                      i_acc,
    input  wire logic [1:0]                      i_omega,   // [0] enable, [1] +1 deg
    rotate_if.requester                          rot,
    output logic signed [race_pkg::MAP_X_W-1:0]  o_x,
    output logic signed [race_pkg::MAP_Y_W-1:0]  o_y,
    output logic [race_pkg::VEL_W-2:0]           o_speed,
    output race_pkg::ang_t                       o_angle,
    output race_pkg::lap_t                       o_lap
);
    import race_pkg::*;

    pos_x_t x_r, x_nxt;
    pos_y_t y_r, y_nxt;
    vel_t   speed_r, speed_nxt;
    ang_t   angle_r, angle_nxt;
    logic   start_r;
    logic signed [VEL_W+1:0]   acc_fx;
    logic signed [VEL_W+1:0]   spd_sum;   // headroom before the clamp
    logic signed [POS_X_W:0]   x_sum;
    logic signed [POS_Y_W:0]   y_sum;
    logic signed [MAP_X_W-1:0] x_int;
    logic signed [MAP_Y_W-1:0] y_int;

    always_comb begin
        acc_fx  = i_acc;
        spd_sum = speed_r - (speed_r >>> FRICTION_SHIFT) + (acc_fx <<< ACC_SHIFT);
        if (spd_sum < 0)
            speed_nxt = '0;
        else if (spd_sum > VEL_MAX_FX)
            speed_nxt = vel_t'(VEL_MAX_FX);
        else
            speed_nxt = vel_t'(spd_sum);

        angle_nxt = angle_r;
        if (i_omega[0]) begin
            if (i_omega[1])
                angle_nxt = (angle_r == ang_t'(ANG_WRAP - 1)) ? '0 : angle_r + 1'b1;
            else
                angle_nxt = (angle_r == '0) ? ang_t'(ANG_WRAP - 1) : angle_r - 1'b1;
        end

        // move by the rotated vector and keep inside the map
        x_sum = x_r + rot.vx;
        y_sum = y_r + rot.vy;
        if (x_sum < (X_MIN <<< FRAC_W))
            x_nxt = pos_x_t'(X_MIN <<< FRAC_W);
        else if (x_sum > (X_MAX <<< FRAC_W))
            x_nxt = pos_x_t'(X_MAX <<< FRAC_W);
        else
            x_nxt = pos_x_t'(x_sum);
        if (y_sum < (Y_MIN <<< FRAC_W))
            y_nxt = pos_y_t'(Y_MIN <<< FRAC_W);
        else if (y_sum > (Y_MAX <<< FRAC_W))
            y_nxt = pos_y_t'(Y_MAX <<< FRAC_W);
        else
            y_nxt = pos_y_t'(y_sum);
    end

    // kick the rotator one clock after the tick
    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n)
            start_r <= 1'b0;
        else
            start_r <= i_frame_tick;
    end

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n) begin
            x_r     <= i_init_x;
            y_r     <= i_init_y;
            speed_r <= '0;
            angle_r <= ang_t'(CAR_INIT_ANGLE);
        end else if (!i_racing) begin
            x_r     <= i_init_x;   // parked on the grid
            y_r     <= i_init_y;
            speed_r <= '0;
            angle_r <= ang_t'(CAR_INIT_ANGLE);
        end else if (rot.done) begin
            x_r     <= x_nxt;
            y_r     <= y_nxt;
            speed_r <= speed_nxt;
            angle_r <= angle_nxt;
        end
    end

    assign rot.start   = start_r;
    assign rot.speed   = speed_r;
    assign rot.heading = angle_r;

    lap_tracker u_lap (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n                   (i_rst_n),
        .i_update                  (i_racing && rot.done),
        .i_clear                   (!i_racing),
        .i_x                       (x_nxt),
        .i_y                       (y_nxt),
        .o_lap                     (o_lap)
    );

    // round to nearest whole unit
    assign x_int   = MAP_X_W'(x_r >>> FRAC_W);
    assign y_int   = MAP_Y_W'(y_r >>> FRAC_W);
    assign o_x     = x_int + MAP_X_W'(x_r[FRAC_W-1]);
    assign o_y     = y_int + MAP_Y_W'(y_r[FRAC_W-1]);
    assign o_speed = speed_r[VEL_W-2:0];   // never negative
    assign o_angle = angle_r;

endmodule

`default_nettype wire

//--- logic/race_control.sv
`timescale 1ns/1ps
`default_nettype none

module race_control (
    input  wire logic           car1_v_decomposition_done,
    input  wire logic           i_rst_n,
    input  wire logic           i_start,
    input  wire logic           i_restart,
    input  wire race_pkg::lap_t i_car1_lap,
    input  wire race_pkg::lap_t i_car2_lap,
    output logic                o_frame_tick,
    output logic                o_racing,
    output race_pkg::game_result_t o_game_result
);
    import race_pkg::*;

    logic [FRAME_CNT_W-1:0] frame_cnt;
    race_state_t            state_r, state_nxt;

    assign o_frame_tick = (frame_cnt == FRAME_CNT_W'(FRAME_CYCLES - 1));

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n)
            frame_cnt <= '0;
        else if (o_frame_tick)
            frame_cnt <= '0;
        else
            frame_cnt <= frame_cnt + 1'b1;
    end

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            S_IDLE:
                if (i_start)
                    state_nxt = S_GAME;
            S_GAME: begin
                // car 1 wins a tie
                if (i_car1_lap == lap_t'(LAP_MAX + 1))
                    state_nxt = S_CAR1_WIN;
                else if (i_car2_lap == lap_t'(LAP_MAX + 1))
                    state_nxt = S_CAR2_WIN;
            end
            S_CAR1_WIN, S_CAR2_WIN:
                if (i_restart)
                    state_nxt = S_IDLE;
            default: state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge car1_v_decomposition_done or negedge i_rst_n) begin
        if (!i_rst_n)
            state_r <= S_IDLE;
        else
            state_r <= state_nxt;
    end

    assign o_racing = (state_r == S_GAME);

    always_comb begin
        case (state_r)
            S_CAR1_WIN: o_game_result = GAME_RESULT_CAR1_WIN;
            S_CAR2_WIN: o_game_result = GAME_RESULT_CAR2_WIN;
            default:    o_game_result = GAME_RESULT_IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/racing_core.sv
`timescale 1ns/1ps
`default_nettype none

module racing_core (
    input  wire logic                           car1_v_decomposition_done,
    input  wire logic                           i_rst_n,
    input  wire logic                           i_start,
    input  wire logic                           i_restart,
    input  wire logic [2:0]                     i_car1_acc,
    input  wire logic [1:0]                     i_car1_omega,
    input  wire logic [2:0]                     i_car2_acc,
    input  wire logic [1:0]                     i_car2_omega,
    output logic signed [race_pkg::MAP_X_W-1:0] o_car1_x,
    output logic signed [race_pkg::MAP_Y_W-1:0] o_car1_y,
    output logic [race_pkg::VEL_W-2:0]          o_car1_speed,
    output race_pkg::ang_t                      o_car1_angle,
    output race_pkg::lap_t                      o_car1_lap,
    output logic signed [race_pkg::MAP_X_W-1:0] o_car2_x,
    output logic signed [race_pkg::MAP_Y_W-1:0] o_car2_y,
    output logic [race_pkg::VEL_W-2:0]          o_car2_speed,
    output race_pkg::ang_t                      o_car2_angle,
    output race_pkg::lap_t                      o_car2_lap,
    output logic                                o_is_gaming,
    output race_pkg::game_result_t              o_game_result
);
    import race_pkg::*;

    logic frame_tick;

    rotate_if rot1_bus ();
    rotate_if rot2_bus ();

    race_control u_ctrl (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_restart      (i_restart),
        .i_car1_lap     (o_car1_lap),
        .i_car2_lap     (o_car2_lap),
        .o_frame_tick   (frame_tick),
        .o_racing       (o_is_gaming),
        .o_game_result  (o_game_result)
    );

    car_dynamics u_car1 (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n      (i_rst_n),
        .i_frame_tick (frame_tick),
        .i_racing     (o_is_gaming),
        .i_init_x     (pos_x_t'(CAR1_INIT_X <<< FRAC_W)),
        .i_init_y     (pos_y_t'(CAR1_INIT_Y <<< FRAC_W)),
        .i_acc        (i_car1_acc),
        .i_omega      (i_car1_omega),
        .rot          (rot1_bus.requester),
        .o_x          (o_car1_x),
        .o_y          (o_car1_y),
        .o_speed      (o_car1_speed),
        .o_angle      (o_car1_angle),
        .o_lap        (o_car1_lap)
    );

    car_dynamics u_car2 (
        .car1_v_decomposition_done (car1_v_decomposition_done),
        .i_rst_n      (i_rst_n),
        .i_frame_tick (frame_tick),
        .i_racing     (o_is_gaming),
        .i_init_x     (pos_x_t'(CAR2_INIT_X <<< FRAC_W)),
        .i_init_y     (pos_y_t'(CAR2_INIT_Y <<< FRAC_W)),
        .i_acc        (i_car2_acc),
        .i_omega      (i_car2_omega),
        .rot          (rot2_bus.requester),
        .o_x          (o_car2_x),
        .o_y          (o_car2_y),
        .o_speed      (o_car2_speed),
        .o_angle      (o_car2_angle),
        .o_lap        (o_car2_lap)
    );

    vector_rotator u_rot1 (
        .i_clk   (car1_v_decomposition_done),
        .i_rst_n (i_rst_n),
        .rot     (rot1_bus.rotator)
    );

    vector_rotator u_rot2 (
        .i_clk   (car1_v_decomposition_done),
        .i_rst_n (i_rst_n),
        .rot     (rot2_bus.rotator)
    );

endmodule

`default_nettype wire

//--- sim/tb_racing_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_racing_core;
    import race_pkg::*;

    localparam int MAX_LINES    = 32;
    localparam int SAMPLE_EDGES = ROT_ITERS + 3;   // race state settled and cars not yet parked
    localparam int MOVE_TOL     = 24;              // rounding plus cordic truncation in 1/16

    logic clk;
    logic rst_n;
    logic start;
    logic restart;
    logic [2:0] acc [2];
    logic [1:0] omega [2];
    logic signed [MAP_X_W-1:0] car_x [2];
    logic signed [MAP_Y_W-1:0] car_y [2];
    logic [VEL_W-2:0] car_speed [2];
    ang_t car_angle [2];
    lap_t car_lap [2];
    logic is_gaming;
    game_result_t game_result;

    logic [47:0] stim [MAX_LINES];
    int n_lines;
    int total_frames;
    longint wd_ns;
    logic wd_ready;

    // reference model
    int m_state;             // 0 idle, 1 game, 2 car 1 won, 3 car 2 won
    int m_speed [2];
    int m_angle [2];
    int m_lap [2];
    bit z0 [2];
    bit z1 [2];
    bit zknown [2];
    int prev_x [2];
    int prev_y [2];
    int prev_speed [2];
    int prev_angle [2];
    int init_x [2];
    int init_y [2];
    bit updated;
    bit wall_hit;

    int checks;
    int errors;
    int tests;
    int tests_failed;

    racing_core u_dut (
        .car1_v_decomposition_done (clk),
        .i_rst_n       (rst_n),
        .i_start       (start),
        .i_restart     (restart),
        .i_car1_acc    (acc[0]),
        .i_car1_omega  (omega[0]),
        .i_car2_acc    (acc[1]),
        .i_car2_omega  (omega[1]),
        .o_car1_x      (car_x[0]),
        .o_car1_y      (car_y[0]),
        .o_car1_speed  (car_speed[0]),
        .o_car1_angle  (car_angle[0]),
        .o_car1_lap    (car_lap[0]),
        .o_car2_x      (car_x[1]),
        .o_car2_y      (car_y[1]),
        .o_car2_speed  (car_speed[1]),
        .o_car2_angle  (car_angle[1]),
        .o_car2_lap    (car_lap[1]),
        .o_is_gaming   (is_gaming),
        .o_game_result (game_result)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic compare_value(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_near(input string name, input int got, input int exp,
                                input int tol);
        checks++;
        assert (got >= exp - tol && got <= exp + tol) else begin
            $display("FAIL t=%0t %s got %0d expected %0d within %0d",
                     $time, name, got, exp, tol);
            errors++;
        end
    endtask

    task automatic park_car(input int c);
        m_speed[c] = 0;
        m_angle[c] = CAR_INIT_ANGLE;
        m_lap[c]   = 0;
        z0[c]      = 1'b1;     // start zones left of the line
        z1[c]      = 1'b0;
        zknown[c]  = 1'b1;
    endtask

    // one frame of speed and heading
    task automatic step_car(input int c, input int a, input int om);
        int n;
        prev_speed[c] = m_speed[c];
        prev_angle[c] = m_angle[c];
        n = m_speed[c] - (m_speed[c] >> FRICTION_SHIFT) + (a << ACC_SHIFT);
        if (n < 0)
            n = 0;
        if (n > VEL_MAX * 16)
            n = VEL_MAX * 16;
        m_speed[c] = n;
        if (om[0])
            m_angle[c] = om[1] ? (m_angle[c] + 1) % 360 : (m_angle[c] + 359) % 360;
    endtask

    task automatic advance_model(input bit s, input bit r);
        updated = 1'b0;
        case (m_state)
            0: if (s) begin
                m_state = 1;
                updated = 1'b1;
            end
            1: updated = 1'b1;
            default: if (r) m_state = 0;
        endcase
        for (int c = 0; c < 2; c++) begin
            if (updated)
                step_car(c, acc[c], omega[c]);
            else
                park_car(c);
        end
    endtask

    task automatic check_lap(input int c, input string tag);
        bit amb;
        bit nz0;
        bit nz1;
        amb = (car_y[c] == 0) || (car_y[c] > 0 && car_x[c] == 0);   // rounding hides the zone
        nz0 = (car_y[c] > 0) && (car_x[c] < 0);
        nz1 = (car_y[c] > 0) && (car_x[c] > 0);
        if (amb || !zknown[c]) begin
            compare_near({tag, "_lap"}, car_lap[c], m_lap[c], 1);
            m_lap[c] = car_lap[c];
        end else begin
            if (z0[c] && nz1)
                m_lap[c]++;
            else if (z1[c] && nz0 && m_lap[c] > 0)
                m_lap[c]--;
            compare_value({tag, "_lap"}, car_lap[c], m_lap[c]);
        end
        z0[c]     = nz0;
        z1[c]     = nz1;
        zknown[c] = !amb;
    endtask

    task automatic check_motion(input int c, input string tag);
        int reach;
        compare_near({tag, "_x_in_map"}, car_x[c], 0, X_MAX);
        compare_near({tag, "_y_in_map"}, car_y[c], 0, Y_MAX);
        if (prev_angle[c] != 0)
            return;
        compare_value({tag, "_y"}, car_y[c], prev_y[c]);   // vy is exactly 0 at heading 0
        reach = prev_x[c] * 16 + prev_speed[c];
        if (reach >= X_MAX * 16 + MOVE_TOL) begin
            compare_value({tag, "_x_at_wall"}, car_x[c], X_MAX);
            if (car_x[c] == X_MAX)
                wall_hit = 1'b1;
        end else if (car_x[c] != X_MAX) begin
            compare_near({tag, "_dx"}, (car_x[c] - prev_x[c]) * 16, prev_speed[c], MOVE_TOL);
        end
    endtask

    task automatic check_frame();
        string tag;
        for (int c = 0; c < 2; c++) begin
            tag = $sformatf("car%0d", c + 1);
            compare_value({tag, "_speed"}, car_speed[c], m_speed[c]);
            compare_value({tag, "_angle"}, car_angle[c], m_angle[c]);
            if (updated) begin
                check_lap(c, tag);
                check_motion(c, tag);
            end else begin
                compare_value({tag, "_x"}, car_x[c], init_x[c]);
                compare_value({tag, "_y"}, car_y[c], init_y[c]);
                compare_value({tag, "_lap"}, car_lap[c], 0);
            end
            prev_x[c] = car_x[c];
            prev_y[c] = car_y[c];
        end
        if (m_state == 1 && m_lap[0] == LAP_MAX + 1)
            m_state = 2;
        else if (m_state == 1 && m_lap[1] == LAP_MAX + 1)
            m_state = 3;
        compare_value("o_is_gaming", is_gaming, m_state == 1);
        compare_value("o_game_result", game_result, m_state >= 2 ? m_state - 1 : 0);
    endtask

    // returns on the edge that follows a frame tick
    task automatic wait_tick();
        while (!u_dut.frame_tick) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    initial begin
        int cnt;
        int err0;
        logic [47:0] w;
        void'($urandom(87277));
        rst_n    = 1'b0;
        start    = 1'b0;
        restart  = 1'b0;
        acc[0]   = '0;
        acc[1]   = '0;
        omega[0] = '0;
        omega[1] = '0;
        wd_ready = 1'b0;
        checks   = 0;
        errors   = 0;
        tests    = 0;
        tests_failed = 0;
        wall_hit = 1'b0;
        m_state  = 0;
        init_x[0] = CAR1_INIT_X;
        init_y[0] = CAR1_INIT_Y;
        init_x[1] = CAR2_INIT_X;
        init_y[1] = CAR2_INIT_Y;
        for (int i = 0; i < MAX_LINES; i++)
            stim[i] = '0;
        $readmemh("sim/race_stim.mem", stim);
        n_lines = 0;
        total_frames = 0;
        while (n_lines < MAX_LINES && stim[n_lines][11:0] != 0) begin
            total_frames += stim[n_lines][11:0];
            n_lines++;
        end
        wd_ns = longint'(total_frames + 10) * FRAME_CYCLES * 8;
        wd_ready = 1'b1;
        for (int c = 0; c < 2; c++) begin
            park_car(c);
            prev_x[c] = init_x[c];
            prev_y[c] = init_y[c];
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        #1;
        err0 = errors;
        updated = 1'b0;
        check_frame();
        report_test("reset", err0);

        for (int l = 0; l < n_lines; l++) begin
            w    = stim[l];
            cnt  = w[11:0];
            err0 = errors;
            for (int f = 0; f < cnt; f++) begin
                wait_tick();
                start   <= w[44];
                restart <= w[40];
                if (w[12]) begin
                    acc[0]   <= 3'($urandom % 8);
                    omega[0] <= 2'($urandom % 4);
                    acc[1]   <= 3'($urandom % 8);
                    omega[1] <= 2'($urandom % 4);
                end else begin
                    acc[0]   <= w[38:36];
                    omega[0] <= w[33:32];
                    acc[1]   <= w[30:28];
                    omega[1] <= w[25:24];
                end
                #1;
                advance_model(w[44], w[40]);
                repeat (SAMPLE_EDGES) @(posedge clk);
                #1;
                check_frame();
            end
            compare_value("o_is_gaming at line end", is_gaming, w[20]);
            compare_value("o_game_result at line end", game_result, w[17:16]);
            report_test($sformatf("line %0d (%0d frames)", l + 1, cnt), err0);
        end

        err0 = errors;
        checks++;
        assert (wall_hit) else begin
            $display("car never came to rest against the right map edge");
            errors++;
        end
        report_test("wall stop", err0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // watchdog sized from the frame count in the stim file
    initial begin
        wait (wd_ready);
        #(wd_ns);
        $display("timeout after %0d ns, frames did not complete", wd_ns);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- racing_core.f
logic/race_pkg.sv
logic/rotate_if.sv
logic/vector_rotator.sv
logic/lap_tracker.sv
logic/car_dynamics.sv
logic/race_control.sv
logic/racing_core.sv
sim/tb_racing_core.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_racing_core \
    -f racing_core.f -o sim_racing_core \
    && out=$(./obj_dir/sim_racing_core) \
    && echo "$out" \
    && echo "$out" | grep -qx "TEST RESULT: PASS" \
    && exit 0 \
    || exit 1

//--- sim/race_stim.mem
// digits: start restart car1_acc car1_omega car2_acc car2_omega
//         exp_gaming exp_result random frame_count(3)
007373000003  // idle, throttle and steering ignored
107020100001  // start
007020100078  // car 1 full throttle right into the wall, car 2 slow
00010010005A  // coast and steer down
007000100050  // drive down to the bottom edge
00010010005A  // coast and steer left
0070001000A0  // drive left across the map
00010010005A  // coast and steer up
00700010005A  // drive up into the top-left corner
00010010005A  // coast and steer right
007000010064  // cross the line again, car 1 wins
010000000001  // restart
100000100001  // start again
00000010101E  // random throttle and steering
